// File: testbench/lsu_cases.txt
# ctrl={flush,rd,wr,br} f3 exe_sel mem_sel alu rs2 u_imm pc rdata
# then expected: flags={ex_valid,trap,wb_valid} mask addr wdata exe_fwd mem_fwd load_data
2 2 0 1 10000100 a1b2c3d4 0 0 0 5 f 10000100 a1b2c3d4 10000100 10000100 0
3 1 1 1 10000200 0000beef 0 0 0 5 3 10000200 0000beef 00000001 00000001 0
2 1 1 1 10000201 0000beef 0 0 0 5 6 10000200 00beef00 00000000 00000000 0
2 1 2 1 10000202 0000beef abcde000 0 0 5 c 10000200 beef0000 abcde000 abcde000 0
2 0 3 1 10000300 123456a5 0 40000100 0 5 1 10000300 123456a5 40000104 40000104 0
2 0 0 2 10000301 123456a5 0 40000200 0 5 2 10000300 3456a500 10000301 40000204 0
2 0 3 2 10000302 123456a5 0 fffffffc 0 5 4 10000300 56a50000 00000000 00000000 0
2 0 0 1 10000303 123456a5 0 0 0 5 8 10000300 a5000000 10000303 10000303 0
2 2 0 1 10000106 cafef00d 0 0 0 5 f 10000106 cafef00d 10000106 10000106 0
4 2 0 0 20000000 0 0 0 8091a2f3 5 f 20000000 0 20000000 8091a2f3 8091a2f3
4 0 0 0 20000010 0 0 0 8091a2f3 5 1 20000010 0 20000010 fffffff3 fffffff3
4 0 0 0 20000011 0 0 0 12345678 5 2 20000010 0 20000011 00000056 00000056
4 0 0 0 20000012 0 0 0 8091a2f3 5 4 20000010 0 20000012 ffffff91 ffffff91
4 0 0 0 20000013 0 0 0 8091a2f3 5 8 20000010 0 20000013 ffffff80 ffffff80
4 4 0 0 20000020 0 0 0 8091a2f3 5 1 20000020 0 20000020 000000f3 000000f3
4 4 0 0 20000021 0 0 0 8091a2f3 5 2 20000020 0 20000021 000000a2 000000a2
4 4 0 0 20000022 0 0 0 8091a2f3 5 4 20000020 0 20000022 00000091 00000091
4 4 0 0 20000023 0 0 0 8091a2f3 5 8 20000020 0 20000023 00000080 00000080
4 1 0 0 20000040 0 0 0 8091a2f3 5 3 20000040 0 20000040 ffffa2f3 ffffa2f3
4 1 0 0 20000041 0 0 0 12345678 5 6 20000040 0 20000041 00003456 00003456
4 1 0 0 20000042 0 0 0 8091a2f3 5 c 20000040 0 20000042 ffff8091 ffff8091
4 5 0 0 20000050 0 0 0 8091a2f3 5 3 20000050 0 20000050 0000a2f3 0000a2f3
4 5 0 0 20000051 0 0 0 8091a2f3 5 6 20000050 0 20000051 000091a2 000091a2
4 5 0 0 20000052 0 0 0 8091a2f3 5 c 20000050 0 20000052 00008091 00008091
2 1 0 1 30000003 0000beef 0 0 0 7 0 30000000 ef000000 30000003 30000003 0
4 5 0 1 3000000b 0 0 0 0 7 0 30000008 0 3000000b 3000000b 0
4 3 0 1 30000010 0 0 0 0 7 0 30000010 0 30000010 30000010 0
a 0 0 1 50000001 000000aa 0 0 0 0 2 50000000 0000aa00 50000001 50000001 0
0 0 0 1 50000010 0 0 0 0 5 2 50000000 0 50000010 50000010 0

// File: vlog.f
common/lsu_pkg.sv
common/mem_stage_if.sv
mem_stage/load_extract.sv
mem_stage/exe_mem_stage.sv
mem_stage/mem_wb_stage.sv
hw/lsu_top.sv
testbench/clk_gen.sv
testbench/lsu_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module lsu_tb -f vlog.f -o lsu_sim > build.log 2>&1 &&
./obj_dir/lsu_sim > sim.log 2>&1 &&
! grep -q "Regression failed" sim.log &&
echo "simulation finished, see sim.log" ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }

// File: testbench/lsu_tb.sv
module lsu_tb
    import lsu_pkg::*;
();

    localparam int PERIOD = 40;

    logic         clk;
    logic         rst;
    logic         ex_ld;
    logic         flush;
    logic         br_en;
    logic         mem_read;
    logic         mem_write;
    logic         wb_ld;
    word_t        alu_out, rs2, u_imm, pc, mem_rdata;
    mem_funct3_u  funct3;
    exe_fwd_sel_e exe_fwd_sel;
    mem_fwd_sel_e mem_fwd_sel;
    word_t        mem_address, mem_wdata, exe_fwd_data, mem_fwd_data, load_data;
    mask_t        mem_byte_enable;
    logic         mem_trap, ex_valid, wb_valid;

    string        lines[$];
    int           n_cases  = 0;
    int           case_idx = 0;
    int           checks   = 0;
    int           errors   = 0;
    logic         loaded   = 1'b0;

    clk_gen #(.PERIOD(PERIOD)) u_clk_gen (.clk_o(clk));

    lsu_top #(
        .RESET_PC (32'h4000_0000)
    ) uut (
        .clk               (clk),
        .rst               (rst),
        .ex_ld_i           (ex_ld),
        .flush_i           (flush),
        .alu_out_i         (alu_out),
        .rs2_i             (rs2),
        .u_imm_i           (u_imm),
        .pc_i              (pc),
        .br_en_i           (br_en),
        .mem_read_i        (mem_read),
        .mem_write_i       (mem_write),
        .funct3_i          (funct3),
        .exe_fwd_sel_i     (exe_fwd_sel),
        .mem_fwd_sel_i     (mem_fwd_sel),
        .mem_address_o     (mem_address),
        .mem_wdata_o       (mem_wdata),
        .exe_fwd_data_o    (exe_fwd_data),
        .mem_byte_enable_o (mem_byte_enable),
        .mem_trap_o        (mem_trap),
        .ex_valid_o        (ex_valid),
        .wb_ld_i           (wb_ld),
        .mem_rdata_i       (mem_rdata),
        .mem_fwd_data_o    (mem_fwd_data),
        .load_data_o       (load_data),
        .wb_valid_o        (wb_valid)
    );

    task automatic word_compare(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s case %0d: got %h, expected %h", name, case_idx, got, exp);
        end
    endtask

    task automatic mask_compare(input string name, input mask_t got, input mask_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s case %0d: got %h, expected %h", name, case_idx, got, exp);
        end
    endtask

    task automatic bit_compare(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s case %0d: got %h, expected %h", name, case_idx, got, exp);
        end
    endtask

    initial begin
        int         fd;
        string      line;
        logic [3:0] ctrl, flags;
        logic [2:0] f3;
        logic [1:0] es, ms;
        mask_t      e_mask;
        word_t      a, r2, ui, p, rd, e_addr, e_wdata, e_efwd, e_mfwd, e_ld;

        void'($urandom(32'h9a3f_cbd8));
        rst         = 1'b1;
        ex_ld       = 1'b0;
        flush       = 1'b0;
        br_en       = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        wb_ld       = 1'b0;
        alu_out     = '0;
        rs2         = '0;
        u_imm       = '0;
        pc          = '0;
        mem_rdata   = '0;
        funct3      = mem_funct3_u'(3'b000);
        exe_fwd_sel = exe_sel_alu_out;
        mem_fwd_sel = mem_sel_mem_data;

        fd = $fopen("testbench/lsu_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/lsu_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                // 8'h23 is the '#' that starts a comment line
                if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != 8'h23)
                    lines.push_back(line);
            end
            $fclose(fd);
        end
        n_cases = lines.size();
        if (n_cases == 0) begin
            errors++;
            $display("No cases were read from the case file");
        end
        loaded = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        bit_compare("ex_valid_o", ex_valid, 1'b0);
        bit_compare("wb_valid_o", wb_valid, 1'b0);
        bit_compare("mem_trap_o", mem_trap, 1'b0);
        mask_compare("mem_byte_enable_o", mem_byte_enable, '0);

        foreach (lines[i]) begin
            case_idx = i + 1;
            if ($sscanf(lines[i], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        ctrl, f3, es, ms, a, r2, ui, p, rd,
                        flags, e_mask, e_addr, e_wdata, e_efwd, e_mfwd, e_ld) != 16) begin
                errors++;
                $display("Case %0d could not be parsed", case_idx);
            end else begin
                flush       = ctrl[3];
                mem_read    = ctrl[2];
                mem_write   = ctrl[1];
                br_en       = ctrl[0];
                funct3      = mem_funct3_u'(f3);
                exe_fwd_sel = exe_fwd_sel_e'(es);
                mem_fwd_sel = mem_fwd_sel_e'(ms);
                alu_out     = a;
                rs2         = ctrl[2] ? $urandom() : r2; // unused on loads
                u_imm       = ui;
                pc          = p;
                ex_ld       = 1'b1;
                @(negedge clk);
                ex_ld     = 1'b0;
                flush     = 1'b0;
                wb_ld     = 1'b1;
                mem_rdata = (ctrl[2] || ms == 2'd0) ? rd : $urandom();
                bit_compare("ex_valid_o", ex_valid, flags[2]);
                bit_compare("mem_trap_o", mem_trap, flags[1]);
                mask_compare("mem_byte_enable_o", mem_byte_enable, e_mask);
                word_compare("mem_address_o", mem_address, e_addr);
                word_compare("exe_fwd_data_o", exe_fwd_data, e_efwd);
                if (ctrl[1])
                    word_compare("mem_wdata_o", mem_wdata, e_wdata);
                @(negedge clk);
                wb_ld = 1'b0;
                bit_compare("wb_valid_o", wb_valid, flags[0]);
                word_compare("mem_fwd_data_o", mem_fwd_data, e_mfwd);
                if (ctrl[2] && !flags[1])
                    word_compare("load_data_o", load_data, e_ld);
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // four cycles allowed for each two-cycle case
    initial begin
        wait (loaded);
        #((n_cases + 10) * 4 * PERIOD);
        $display("Timeout: the cases did not finish in the expected time");
        $display("Regression failed");
        $finish;
    end

endmodule : lsu_tb

// File: testbench/clk_gen.sv
module clk_gen #(
    parameter int PERIOD = 40
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD / 2) clk_o = ~clk_o; // 50% duty

endmodule : clk_gen

// File: hw/lsu_top.sv
module lsu_top
    import lsu_pkg::*;
#(
    parameter word_t RESET_PC = 32'h4000_0000
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         ex_ld_i,
    input  logic         flush_i,
    input  word_t        alu_out_i,
    input  word_t        rs2_i,
    input  word_t        u_imm_i,
    input  word_t        pc_i,
    input  logic         br_en_i,
    input  logic         mem_read_i,
    input  logic         mem_write_i,
    input  mem_funct3_u  funct3_i,
    input  exe_fwd_sel_e exe_fwd_sel_i,
    input  mem_fwd_sel_e mem_fwd_sel_i,
    output word_t        mem_address_o,
    output word_t        mem_wdata_o,
    output word_t        exe_fwd_data_o,
    output mask_t        mem_byte_enable_o,
    output logic         mem_trap_o,
    output logic         ex_valid_o,
    input  logic         wb_ld_i,
    input  word_t        mem_rdata_i,
    output word_t        mem_fwd_data_o,
    output word_t        load_data_o,
    output logic         wb_valid_o
);

    mem_stage_if stage_if ();

    exe_mem_stage #(
        .RESET_PC (RESET_PC)
    ) u_exe_mem_stage (
        .clk               (clk),
        .rst               (rst),
        .ex_ld_i           (ex_ld_i),
        .flush_i           (flush_i),
        .alu_out_i         (alu_out_i),
        .rs2_i             (rs2_i),
        .u_imm_i           (u_imm_i),
        .pc_i              (pc_i),
        .br_en_i           (br_en_i),
        .mem_read_i        (mem_read_i),
        .mem_write_i       (mem_write_i),
        .funct3_i          (funct3_i),
        .exe_fwd_sel_i     (exe_fwd_sel_i),
        .mem_fwd_sel_i     (mem_fwd_sel_i),
        .mem_address_o     (mem_address_o),
        .mem_wdata_o       (mem_wdata_o),
        .exe_fwd_data_o    (exe_fwd_data_o),
        .mem_byte_enable_o (mem_byte_enable_o),
        .mem_trap_o        (mem_trap_o),
        .ex_valid_o        (ex_valid_o),
        .stage_o           (stage_if.src)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk            (clk),
        .rst            (rst),
        .wb_ld_i        (wb_ld_i),
        .mem_rdata_i    (mem_rdata_i),
        .stage_i        (stage_if.dst),
        .mem_fwd_data_o (mem_fwd_data_o),
        .load_data_o    (load_data_o),
        .wb_valid_o     (wb_valid_o)
    );

endmodule : lsu_top

// File: mem_stage/mem_wb_stage.sv
module mem_wb_stage
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_ld_i,
    input  word_t       mem_rdata_i,
    mem_stage_if.dst    stage_i,
    output word_t       mem_fwd_data_o,
    output word_t       load_data_o,
    output logic        wb_valid_o
);

    word_t load_data;
    word_t fwd_d;

    load_extract u_load_extract (
        .rdata_i  (mem_rdata_i),
        .offset_i (stage_i.offset),
        .funct3_i (stage_i.funct3),
        .data_o   (load_data)
    );

    always_comb begin
        case (stage_i.mem_fwd_sel)
            mem_sel_mem_data:  fwd_d = load_data;
            mem_sel_pc_plus_4: fwd_d = stage_i.pc + word_t'(PC_STEP);
            default:           fwd_d = stage_i.exe_fwd;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            wb_valid_o <= 1'b0;
        else if (wb_ld_i)
            wb_valid_o <= stage_i.valid; // a flushed item stays invalid
    end

    always_ff @(posedge clk) begin
        if (wb_ld_i)
            mem_fwd_data_o <= fwd_d;
        if (wb_ld_i && stage_i.is_load)
            load_data_o <= load_data; // keeps last loaded value
    end

endmodule : mem_wb_stage

// File: mem_stage/exe_mem_stage.sv
module exe_mem_stage
    import lsu_pkg::*;
#(
    parameter word_t RESET_PC = 32'h4000_0000
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          ex_ld_i,
    input  logic          flush_i,
    input  word_t         alu_out_i,
    input  word_t         rs2_i,
    input  word_t         u_imm_i,
    input  word_t         pc_i,
    input  logic          br_en_i,
    input  logic          mem_read_i,
    input  logic          mem_write_i,
    input  mem_funct3_u   funct3_i,
    input  exe_fwd_sel_e  exe_fwd_sel_i,
    input  mem_fwd_sel_e  mem_fwd_sel_i,
    output word_t         mem_address_o,
    output word_t         mem_wdata_o,
    output word_t         exe_fwd_data_o,
    output mask_t         mem_byte_enable_o,
    output logic          mem_trap_o,
    output logic          ex_valid_o,
    mem_stage_if.src      stage_o
);

    offset_t      offset;
    word_t        fwd_d, addr_d, wdata_d;
    mask_t        mask_d;
    logic         trap_d;
    logic         mem_access;
    logic         valid_q, is_load_q;
    word_t        fwd_q, pc_q;
    mem_funct3_u  funct3_q;
    offset_t      offset_q;
    mem_fwd_sel_e mem_fwd_sel_q;

    assign offset     = alu_out_i[1:0];
    assign mem_access = mem_read_i || mem_write_i;

    always_comb begin
        case (exe_fwd_sel_i)
            exe_sel_alu_out:    fwd_d = alu_out_i;
            exe_sel_br_en_zext: fwd_d = {{(XLEN-1){1'b0}}, br_en_i};
            exe_sel_u_imm:      fwd_d = u_imm_i;
            default:            fwd_d = pc_i + word_t'(PC_STEP); // jal/jalr link
        endcase
    end

    always_comb begin
        addr_d  = {alu_out_i[XLEN-1:2], 2'b00};
        wdata_d = rs2_i << {offset, 3'b000}; // move data onto its lanes
        mask_d  = '0;
        trap_d  = 1'b0;
        if (mem_read_i) begin
            case (funct3_i.load)
                lw: begin
                    addr_d = alu_out_i;
                    mask_d = '1;
                end
                lh, lhu: begin
                    if (offset == 2'd3)
                        trap_d = 1'b1; // would cross the word
                    else
                        mask_d = mask_t'(2'b11) << offset;
                end
                lb, lbu: mask_d = mask_t'(1'b1) << offset;
                default: trap_d = 1'b1;
            endcase
        end else if (mem_write_i) begin
            case (funct3_i.store)
                sw: begin
                    addr_d  = alu_out_i;
                    wdata_d = rs2_i;
                    mask_d  = '1;
                end
                sh: begin
                    if (offset == 2'd3)
                        trap_d = 1'b1;
                    else
                        mask_d = mask_t'(2'b11) << offset;
                end
                sb: mask_d = mask_t'(1'b1) << offset;
                default: trap_d = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            valid_q           <= 1'b0;
            mem_byte_enable_o <= '0;
            mem_trap_o        <= 1'b0;
            pc_q              <= RESET_PC;
            funct3_q          <= '0;
            offset_q          <= '0;
            is_load_q         <= 1'b0;
            mem_fwd_sel_q     <= mem_sel_mem_data;
        end else begin
            if (flush_i)
                valid_q <= 1'b0; // flush wins over load
            else if (ex_ld_i)
                valid_q <= 1'b1;
            if (ex_ld_i) begin
                pc_q          <= pc_i;
                funct3_q      <= funct3_i;
                offset_q      <= offset;
                is_load_q     <= mem_read_i;
                mem_fwd_sel_q <= mem_fwd_sel_i;
            end
            if (ex_ld_i && mem_access) begin
                mem_byte_enable_o <= mask_d;
                mem_trap_o        <= trap_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ld_i)
            fwd_q <= fwd_d;
        if (ex_ld_i && mem_access) begin // cache port holds between accesses
            mem_address_o <= addr_d;
            mem_wdata_o   <= wdata_d;
        end
    end

    assign exe_fwd_data_o      = fwd_q;
    assign ex_valid_o          = valid_q;
    assign stage_o.valid       = valid_q;
    assign stage_o.exe_fwd     = fwd_q;
    assign stage_o.pc          = pc_q;
    assign stage_o.funct3      = funct3_q;
    assign stage_o.offset      = offset_q;
    assign stage_o.is_load     = is_load_q;
    assign stage_o.mem_fwd_sel = mem_fwd_sel_q;

endmodule : exe_mem_stage

// File: mem_stage/load_extract.sv
module load_extract
    import lsu_pkg::*;
(
    input  word_t       rdata_i,
    input  offset_t     offset_i,
    input  mem_funct3_u funct3_i,
    output word_t       data_o
);

    word_t       shifted;
    logic [7:0]  byte_val;
    logic [15:0] half_val;

    // addressed byte/half lands in the low lanes
    assign shifted  = rdata_i >> {offset_i, 3'b000};
    assign byte_val = shifted[7:0];
    assign half_val = shifted[15:0];

    always_comb begin
        case (funct3_i.load)
            lb: begin
                data_o = {{(XLEN-8){byte_val[7]}}, byte_val};
            end
            lbu: begin
                data_o = {{(XLEN-8){1'b0}}, byte_val};
            end
            lh: begin
                data_o = {{(XLEN-16){half_val[15]}}, half_val};
            end
            lhu: begin
                data_o = {{(XLEN-16){1'b0}}, half_val};
            end
            default: begin
                data_o = rdata_i; // lw passes the word unshifted
            end
        endcase
    end

endmodule : load_extract

// File: common/mem_stage_if.sv
interface mem_stage_if
    import lsu_pkg::*;
();

    logic         valid;
    word_t        exe_fwd;
    word_t        pc;
    mem_funct3_u  funct3;
    offset_t      offset; // low address bits of the access
    logic         is_load;
    mem_fwd_sel_e mem_fwd_sel;

    modport src (
        output valid, exe_fwd, pc, funct3, offset, is_load, mem_fwd_sel
    );

    modport dst (
        input valid, exe_fwd, pc, funct3, offset, is_load, mem_fwd_sel
    );

endinterface : mem_stage_if

// File: common/lsu_pkg.sv
package lsu_pkg;

    localparam int XLEN    = 32;
    localparam int LANES   = XLEN / 8;
    localparam int PC_STEP = 4; // link increment

    typedef logic [XLEN-1:0]  word_t;
    typedef logic [LANES-1:0] mask_t;
    typedef logic [1:0]       offset_t; // byte within word

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_e;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_e;

    // one funct3 field, read as load or store depending on the access
    typedef union packed {
        load_funct3_e  load;
        store_funct3_e store;
    } mem_funct3_u;

    typedef enum logic [1:0] {
        exe_sel_alu_out    = 2'b00,
        exe_sel_br_en_zext = 2'b01,
        exe_sel_u_imm      = 2'b10,
        exe_sel_pc_plus_4  = 2'b11
    } exe_fwd_sel_e;

    typedef enum logic [1:0] {
        mem_sel_mem_data  = 2'b00,
        mem_sel_exe_fwd   = 2'b01,
        mem_sel_pc_plus_4 = 2'b10
    } mem_fwd_sel_e;

endpackage : lsu_pkg
